//--- source/console_settings.svh
// Console build settings
`ifndef CONSOLE_SETTINGS_SVH
`define CONSOLE_SETTINGS_SVH

// A key must hold its new level this many clocks before it is accepted.
`define CON_DEBOUNCE_CYCLES 16

// Flops in each panel input synchronizer.
`define CON_SYNC_STAGES 2

// Memory fields built, each one 4096 words.
`define CON_FIELDS 8

`endif

//--- source/pdp_data_pkg.sv
// Machine data types
package pdp_data_pkg;

    // Bit 11 here is bit 0 in PDP numbering, bit 0 is bit 11.
    typedef logic [11:0] word_t;

    // Instruction or data field number.
    typedef logic [2:0] field_t;

    // Field in the top three bits, word address below.
    typedef logic [14:0] ext_addr_t;

endpackage

//--- source/console_ctl_pkg.sv
// Console control types
package console_ctl_pkg;

    typedef enum logic [1:0] {
        con_idle,
        con_read,    // Memory read in flight.
        con_capture  // Read data goes into mb.
    } con_state_t;

    // Position of each line in dsel.
    typedef enum logic [2:0] {
        sel_ma    = 3'd0,
        sel_mb    = 3'd1,
        sel_field = 3'd2,
        sel_sr    = 3'd3,
        sel_ext   = 3'd4,
        sel_none  = 3'd5
    } disp_sel_t;

endpackage

//--- source/panel_cmd_if.sv
// Panel command bundle
interface panel_cmd_if;

    logic                 addr_load;  // One-cycle pulses.
    logic                 extd_addr;
    logic                 dep;
    logic                 exam;
    logic                 clear;
    pdp_data_pkg::word_t  sr;         // Synchronized switch register.

    modport source (
        output addr_load, extd_addr, dep, exam, clear, sr
    );

    modport sink (
        input addr_load, extd_addr, dep, exam, clear, sr
    );

endinterface

//--- source/switch_sync.sv
// Panel key synchronizer and debouncer
`include "console_settings.svh"

module switch_sync (
    input  logic                clk,
    input  logic                rst_n,
    input  logic [4:0]          keys_n,
    input  pdp_data_pkg::word_t sr,
    panel_cmd_if.source         cmd
);

    localparam int NKEYS = 5;
    localparam int SYNC  = `CON_SYNC_STAGES;
    localparam int DB    = `CON_DEBOUNCE_CYCLES;
    localparam int CW    = $clog2(DB + 1);

    // Key positions in keys_n.
    localparam int KEY_CLEAR = 0;
    localparam int KEY_EXAM  = 1;
    localparam int KEY_DEP   = 2;
    localparam int KEY_EXTD  = 3;
    localparam int KEY_LOAD  = 4;

    logic [NKEYS-1:0]    key_sync [SYNC];
    logic [NKEYS-1:0]    key_level;       // Accepted level, active high.
    logic [CW-1:0]       db_cnt [NKEYS];
    logic [NKEYS-1:0]    pulse;
    pdp_data_pkg::word_t sr_sync [SYNC];

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            for (int s = 0; s < SYNC; s++)
                key_sync[s] <= '0;
            for (int k = 0; k < NKEYS; k++)
                db_cnt[k] <= '0;
            key_level <= '0;
            pulse     <= '0;
        end
        else
        begin
            key_sync[0] <= ~keys_n;
            for (int s = 1; s < SYNC; s++)
                key_sync[s] <= key_sync[s-1];
            for (int k = 0; k < NKEYS; k++)
            begin
                pulse[k] <= 1'b0;
                if (key_sync[SYNC-1][k] == key_level[k])
                    db_cnt[k] <= '0;                        // Bounce restarts the count.
                else if (db_cnt[k] == CW'(DB - 1))
                begin
                    key_level[k] <= key_sync[SYNC-1][k];
                    db_cnt[k]    <= '0;
                    pulse[k]     <= key_sync[SYNC-1][k];    // Press edge only.
                end
                else
                    db_cnt[k] <= db_cnt[k] + CW'(1);
            end
        end
    end

    always_ff @(posedge clk)
    begin
        sr_sync[0] <= sr;
        for (int s = 1; s < SYNC; s++)
            sr_sync[s] <= sr_sync[s-1];
    end

    assign cmd.clear     = pulse[KEY_CLEAR];
    assign cmd.exam      = pulse[KEY_EXAM];
    assign cmd.dep       = pulse[KEY_DEP];
    assign cmd.extd_addr = pulse[KEY_EXTD];
    assign cmd.addr_load = pulse[KEY_LOAD];
    assign cmd.sr        = sr_sync[SYNC-1];

    // A held key never yields back-to-back pulses.
    a_single_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        (pulse & $past(pulse)) == '0);

endmodule

//--- source/core_memory.sv
// Core memory array
`include "console_settings.svh"

module core_memory (
    input  logic                    clk,
    input  pdp_data_pkg::ext_addr_t addr,
    input  logic                    we,
    input  pdp_data_pkg::word_t     wdata,
    output pdp_data_pkg::word_t     rdata
);

    localparam int DEPTH = `CON_FIELDS * 4096;

    pdp_data_pkg::word_t mem [DEPTH];

    // Read before write on the same address.
    always_ff @(posedge clk)
    begin
        if (we)
            mem[addr] <= wdata;
        rdata <= mem[addr];
    end

endmodule

//--- source/console_core.sv
// Console command sequencer
module console_core (
    input  logic                 clk,
    input  logic                 rst_n,
    panel_cmd_if.sink            cmd,
    output pdp_data_pkg::word_t  ma,
    output pdp_data_pkg::word_t  mb,
    output pdp_data_pkg::field_t inst_field,
    output pdp_data_pkg::field_t data_field
);

    console_ctl_pkg::con_state_t state;
    pdp_data_pkg::ext_addr_t     mem_addr;
    pdp_data_pkg::word_t         rdata;
    logic                        do_extd;
    logic                        do_load;
    logic                        cmd_free;
    logic                        mem_we;
    logic                        do_exam;
    logic                        ma_step;

    // Priority is clear, extd_addr, addr_load, dep, exam.
    assign do_extd  = cmd.extd_addr && !cmd.clear;
    assign do_load  = cmd.addr_load && !cmd.clear && !cmd.extd_addr;
    assign cmd_free = !cmd.clear && !cmd.extd_addr && !cmd.addr_load
                      && (state == console_ctl_pkg::con_idle);
    assign mem_we   = cmd_free && cmd.dep;
    assign do_exam  = cmd_free && !cmd.dep && cmd.exam;
    assign ma_step  = mem_we
                      || (state == console_ctl_pkg::con_capture && !cmd.clear && !do_load);
    assign mem_addr = {inst_field, ma};

    always_ff @(posedge clk)
    begin
        if (!rst_n || cmd.clear)
            state <= console_ctl_pkg::con_idle;          // Clear also aborts an examine.
        else
        begin
            case (state)
                console_ctl_pkg::con_idle:
                    if (do_exam)
                        state <= console_ctl_pkg::con_read;
                console_ctl_pkg::con_read:
                    state <= console_ctl_pkg::con_capture;
                default:
                    state <= console_ctl_pkg::con_idle;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n || cmd.clear)
        begin
            ma         <= '0;
            mb         <= '0;
            inst_field <= '0;
            data_field <= '0;
        end
        else
        begin
            if (do_extd)
            begin
                inst_field <= cmd.sr[5:3];               // PDP bits 6 to 8.
                data_field <= cmd.sr[2:0];               // PDP bits 9 to 11.
            end
            if (do_load)
                ma <= cmd.sr;
            else if (ma_step)
                ma <= ma + 12'd1;                        // Wraps inside the field.
            if (mem_we)
                mb <= cmd.sr;
            else if (state == console_ctl_pkg::con_capture)
                mb <= rdata;
        end
    end

    core_memory mem_i (
        .clk   (clk),
        .addr  (mem_addr),
        .we    (mem_we),
        .wdata (cmd.sr),
        .rdata (rdata)
    );

    // Nothing is written while an examine read is in flight.
    a_no_write_in_exam: assert property (@(posedge clk) disable iff (!rst_n)
        do_exam |=> !mem_we ##1 !mem_we);

endmodule

//--- source/light_mux.sv
// Front panel lamp driver
module light_mux (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic [5:0]           dsel,
    input  pdp_data_pkg::word_t  ma,
    input  pdp_data_pkg::word_t  mb,
    input  pdp_data_pkg::field_t inst_field,
    input  pdp_data_pkg::field_t data_field,
    input  pdp_data_pkg::word_t  sr,
    output pdp_data_pkg::word_t  an,
    output pdp_data_pkg::field_t eman,
    output pdp_data_pkg::word_t  dsn
);

    console_ctl_pkg::disp_sel_t pick;
    pdp_data_pkg::word_t        disp;

    // Lowest set select line wins.
    always_comb
    begin
        casez (dsel)
            6'b?????1: pick = console_ctl_pkg::sel_ma;
            6'b????10: pick = console_ctl_pkg::sel_mb;
            6'b???100: pick = console_ctl_pkg::sel_field;
            6'b??1000: pick = console_ctl_pkg::sel_sr;
            6'b?10000: pick = console_ctl_pkg::sel_ext;
            default:   pick = console_ctl_pkg::sel_none;
        endcase
    end

    always_comb
    begin
        case (pick)
            console_ctl_pkg::sel_ma:    disp = ma;
            console_ctl_pkg::sel_mb:    disp = mb;
            console_ctl_pkg::sel_field: disp = {6'b000000, inst_field, data_field};
            console_ctl_pkg::sel_sr:    disp = sr;
            console_ctl_pkg::sel_ext:   disp = ma;   // Low word of the examine address.
            default:                    disp = '0;
        endcase
    end

    // Lamps are lit by a low level.
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            an   <= '1;
            eman <= '1;
            dsn  <= '1;
        end
        else
        begin
            an   <= ~ma;
            eman <= ~inst_field;
            dsn  <= ~disp;
        end
    end

    a_lamps_hold: assert property (@(posedge clk)
        rst_n && $past(rst_n) && $stable(dsel) && $stable(ma) && $stable(mb)
        && $stable(inst_field) && $stable(data_field) && $stable(sr)
        |=> $stable(dsn) && $stable(an) && $stable(eman));

endmodule

//--- source/console_top.sv
// Operator console top level
module console_top (
    input  logic                 clk,
    input  logic                 rst_n,
    input  pdp_data_pkg::word_t  sr,
    input  logic [5:0]           dsel,
    input  logic                 addr_loadn,
    input  logic                 extd_addrn,
    input  logic                 depn,
    input  logic                 examn,
    input  logic                 clearn,
    output pdp_data_pkg::word_t  an,
    output pdp_data_pkg::field_t eman,
    output pdp_data_pkg::word_t  dsn
);

    pdp_data_pkg::word_t  ma;
    pdp_data_pkg::word_t  mb;
    pdp_data_pkg::field_t inst_field;
    pdp_data_pkg::field_t data_field;

    panel_cmd_if cmd_bus ();

    switch_sync sync_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .keys_n ({addr_loadn, extd_addrn, depn, examn, clearn}),
        .sr     (sr),
        .cmd    (cmd_bus.source)
    );

    console_core core_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .cmd        (cmd_bus.sink),
        .ma         (ma),
        .mb         (mb),
        .inst_field (inst_field),
        .data_field (data_field)
    );

    light_mux lamps_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .dsel       (dsel),
        .ma         (ma),
        .mb         (mb),
        .inst_field (inst_field),
        .data_field (data_field),
        .sr         (cmd_bus.sr),      // Synchronized copy of the switches.
        .an         (an),
        .eman       (eman),
        .dsn        (dsn)
    );

endmodule

//--- bench/console_tb.sv
// Console testbench
`include "console_settings.svh"

module console_tb;

    localparam int HOLD_CYCLES    = `CON_DEBOUNCE_CYCLES + 8;
    localparam int SETTLE_CYCLES  = 40;
    localparam int TIMEOUT_CYCLES = 4000;  // Tests take about 2700 cycles, plus margin.
    localparam int KEY_LOAD       = 0;
    localparam int KEY_EXTD       = 1;
    localparam int KEY_DEP        = 2;
    localparam int KEY_EXAM       = 3;
    localparam int KEY_CLEAR      = 4;

    logic                 clk = 1'b0;
    logic                 rst_n;
    pdp_data_pkg::word_t  sr;
    logic [5:0]           dsel;
    logic [4:0]           keys_n;
    pdp_data_pkg::word_t  an;
    pdp_data_pkg::field_t eman;
    pdp_data_pkg::word_t  dsn;

    pdp_data_pkg::word_t  mem_model [pdp_data_pkg::ext_addr_t];
    pdp_data_pkg::word_t  m_ma;
    pdp_data_pkg::word_t  m_mb;
    pdp_data_pkg::field_t m_if;
    pdp_data_pkg::field_t m_df;
    pdp_data_pkg::word_t  start;
    int                   seed = 97605;
    int                   cycle_count = 0;
    int                   check_seq = 0;
    int                   check_ack = 0;
    string                test_name;

    console_top dut_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .sr         (sr),
        .dsel       (dsel),
        .addr_loadn (keys_n[KEY_LOAD]),
        .extd_addrn (keys_n[KEY_EXTD]),
        .depn       (keys_n[KEY_DEP]),
        .examn      (keys_n[KEY_EXAM]),
        .clearn     (keys_n[KEY_CLEAR]),
        .an         (an),
        .eman       (eman),
        .dsn        (dsn)
    );

    always #4 clk = ~clk;

    always @(posedge clk)
        cycle_count <= cycle_count + 1;

    // Inverted lamp word for a select setting, lowest set line wins.
    function automatic pdp_data_pkg::word_t ref_lamp(input logic [5:0] sel);
        pdp_data_pkg::word_t disp;
        int                  pos;
        pos = 6;
        for (int i = 5; i >= 0; i--)
            if (sel[i])
                pos = i;
        case (pos)
            0:       disp = m_ma;
            1:       disp = m_mb;
            2:       disp = {6'b000000, m_if, m_df};
            3:       disp = sr;
            4:       disp = m_ma;            // Low word of the examine address.
            default: disp = '0;
        endcase
        return ~disp;
    endfunction

    function automatic pdp_data_pkg::word_t rand_word();
        return pdp_data_pkg::word_t'($random(seed));
    endfunction

    task automatic check_word(input string name, input pdp_data_pkg::word_t exp,
                              input pdp_data_pkg::word_t act);
        if (act !== exp)
        begin
            $display("Mismatch %s: expected %h, actual %h", name, exp, act);
            $display("Finished with errors");
            $fatal(1, "lamp word mismatch");
        end
    endtask

    task automatic check_field(input string name, input pdp_data_pkg::field_t exp,
                               input pdp_data_pkg::field_t act);
        if (act !== exp)
        begin
            $display("Mismatch %s: expected %h, actual %h", name, exp, act);
            $display("Finished with errors");
            $fatal(1, "field lamp mismatch");
        end
    endtask

    // Lamps are compared at the falling edge, away from any input change.
    always @(negedge clk)
    begin
        if (check_ack != check_seq)
        begin
            check_word({test_name, " an"}, ~m_ma, an);
            check_field({test_name, " eman"}, ~m_if, eman);
            check_word({test_name, " dsn"}, ref_lamp(dsel), dsn);
            check_ack = check_seq;
        end
    end

    task automatic next_cycles(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    task automatic expect_lamps(input string name);
        test_name = name;
        check_seq++;
        wait (check_ack == check_seq);
    endtask

    task automatic press_key(input int key, input int hold, input pdp_data_pkg::word_t value);
        next_cycles(1);
        sr          = value;
        keys_n[key] = 1'b0;
        next_cycles(hold);
        keys_n[key] = 1'b1;
        next_cycles(SETTLE_CYCLES);
    endtask

    task automatic show(input logic [5:0] sel);
        next_cycles(1);
        dsel = sel;
        next_cycles(2);
    endtask

    task automatic load_address(input pdp_data_pkg::word_t value);
        press_key(KEY_LOAD, HOLD_CYCLES, value);
        m_ma = value;
    endtask

    task automatic load_fields(input pdp_data_pkg::word_t value);
        press_key(KEY_EXTD, HOLD_CYCLES, value);
        m_if = value[5:3];                   // PDP bits 6 to 8.
        m_df = value[2:0];
    endtask

    task automatic deposit(input pdp_data_pkg::word_t value, input int hold);
        press_key(KEY_DEP, hold, value);
        mem_model[{m_if, m_ma}] = value;
        m_mb = value;
        m_ma = m_ma + 12'd1;
    endtask

    task automatic examine();
        press_key(KEY_EXAM, HOLD_CYCLES, sr);
        m_mb = mem_model[{m_if, m_ma}];
        m_ma = m_ma + 12'd1;
    endtask

    initial
    begin
        wait (cycle_count >= TIMEOUT_CYCLES);
        $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Finished with errors");
        $fatal(1, "simulation timed out");
    end

    initial
    begin
        rst_n  = 1'b0;
        sr     = '0;
        dsel   = '0;
        keys_n = '1;
        m_ma   = '0;
        m_mb   = '0;
        m_if   = '0;
        m_df   = '0;
        next_cycles(2);
        rst_n = 1'b1;
        next_cycles(2);
        expect_lamps("reset");
        show(6'b000001);
        load_address(rand_word());
        expect_lamps("load address");
        show(6'b000100);
        load_fields(rand_word());
        expect_lamps("extended address load");
        show(6'b000010);
        start = rand_word();
        load_address(start);
        for (int i = 0; i < 8; i++)
            deposit(rand_word(), HOLD_CYCLES);
        expect_lamps("deposit");
        load_address(start);
        for (int i = 0; i < 8; i++)
        begin
            examine();
            expect_lamps("examine");
        end
        load_fields({6'b000000, m_if + 3'd1, m_df});   // Next field up.
        load_address(start);
        for (int i = 0; i < 4; i++)
            deposit(rand_word(), HOLD_CYCLES);
        load_address(start);
        for (int i = 0; i < 4; i++)
        begin
            examine();
            expect_lamps("examine second field");
        end
        load_fields({6'b000000, m_if - 3'd1, m_df});   // Back to the first field.
        load_address(start);
        for (int i = 0; i < 4; i++)
        begin
            examine();
            expect_lamps("examine first field again");
        end
        for (int i = 0; i <= 6; i++)
        begin
            show(i < 6 ? 6'(1 << i) : 6'b000000);
            expect_lamps("display select");
        end
        press_key(KEY_CLEAR, HOLD_CYCLES, sr);
        m_ma = '0;
        m_mb = '0;
        m_if = '0;
        m_df = '0;
        show(6'b000100);
        expect_lamps("clear");
        show(6'b000010);
        expect_lamps("clear mb");
        press_key(KEY_DEP, `CON_DEBOUNCE_CYCLES - 4, rand_word());
        expect_lamps("debounce glitch");
        deposit(rand_word(), 4 * `CON_DEBOUNCE_CYCLES);
        expect_lamps("long hold");
        $display("Finished with no errors");
        $finish;
    end

endmodule

//--- list.f
+incdir+source
source/pdp_data_pkg.sv
source/console_ctl_pkg.sv
source/panel_cmd_if.sv
source/switch_sync.sv
source/core_memory.sv
source/console_core.sv
source/light_mux.sv
source/console_top.sv
bench/console_tb.sv

//--- Makefile
# Verilator build for the operator console testbench

VERILATOR ?= verilator
TOP       ?= console_tb
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FILELIST  ?= list.f
PASS_MSG  ?= Finished with no errors
VFLAGS    ?= --binary --timing --assert

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
